//--- include/fifo_test_config.svh
// Build-time sizes for the FIFO test controller, included by RTL and testbench sources
`ifndef FIFO_TEST_CONFIG_SVH
`define FIFO_TEST_CONFIG_SVH

// ====================
// Send test
// ====================

// Number of data packets generated by the send test
`define FTC_SEND_PACKETS 8'd2

// Payload bytes in every generated packet
`define FTC_SEND_PAYLOAD 6'd5

// ====================
// Replies
// ====================

// Longest reply, header byte included
`define FTC_REPLY_BYTES 4

`endif

//--- logic/fifo_proto_pkg.sv
// Link protocol types shared by the controller and the testbench, referenced by package scope
package fifo_proto_pkg;

    // Command in the upper two bits of a header byte
    typedef enum logic [1:0] {
        TEST_START   = 2'd0,
        TEST_DATA    = 2'd1,
        TEST_STOP    = 2'd2,
        TEST_STOPPED = 2'd3    // replies only
    } cmd_e;

    // Payload of a START packet
    typedef enum logic [7:0] {
        RECEIVE      = 8'd1,
        SEND         = 8'd2,
        RECEIVE_SEND = 8'd3
    } test_num_e;

    // First payload byte of a stop report
    typedef enum logic [7:0] {
        NONE             = 8'd0,
        BAD_START_LENGTH = 8'd1,
        BAD_STOP_LENGTH  = 8'd2,
        BAD_CMD          = 8'd3,
        BAD_TEST_NUM     = 8'd4,
        BAD_TEST_DATA    = 8'd5
    } err_code_e;

    // Header byte layout
    typedef struct packed {
        cmd_e       cmd;
        logic [5:0] len;
    } pkt_header_t;

endpackage

//--- logic/fifo_ctrl_pkg.sv
// Internal types of the FIFO test controller, referenced by package scope from its modules
`include "fifo_test_config.svh"

package fifo_ctrl_pkg;

    // Test sequencer FSM
    typedef enum logic [2:0] {
        READ,
        REPLY,
        STREAM,
        REPORT,
        DONE
    } seq_state_e;

    // Parser position inside a packet
    typedef enum logic {
        PH_CMD,
        PH_PAYLOAD
    } parse_phase_e;

    // Writer FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REPLY,
        WR_HDR,
        WR_PAYLOAD
    } wr_state_e;

    // One input byte with its position in the packet
    typedef struct packed {
        logic                 is_header;
        fifo_proto_pkg::cmd_e cmd;
        logic                 last;
        logic [7:0]           data;
    } parsed_byte_t;

    // Reply buffer, or a request for the generated send stream
    typedef struct packed {
        logic                                stream;
        logic [2:0]                          count;
        logic [`FTC_REPLY_BYTES-1:0][7:0]    bytes;
    } reply_req_t;

endpackage

//--- logic/packet_parser.sv
// Input FIFO reader of the FIFO test controller, tags each byte as header or payload
`timescale 1ns/100ps

module packet_parser (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        in_empty_i,
    input  logic [7:0]                  in_data_i,
    input  logic                        accept_i,
    output logic                        in_rd_o,
    output fifo_ctrl_pkg::parsed_byte_t parsed_o,
    output logic                        parsed_valid_o
);

    fifo_ctrl_pkg::parse_phase_e phase;
    fifo_proto_pkg::cmd_e        cur_cmd;
    fifo_proto_pkg::pkt_header_t hdr;
    logic [5:0]                  remaining;
    logic                        rd_pend;
    logic                        in_flight;

    assign hdr = fifo_proto_pkg::pkt_header_t'(in_data_i);

    // A byte counts as in flight until the sequencer has seen it
    assign in_flight = in_rd_o | rd_pend | parsed_valid_o;

    // ====================
    // Read enable
    // ====================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            in_rd_o <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            in_rd_o <= accept_i & ~in_empty_i & ~in_flight;
            // Data shows up one cycle after the read pulse
            rd_pend <= in_rd_o;
        end
    end

    // ====================
    // Byte tagging
    // ====================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            phase          <= fifo_ctrl_pkg::PH_CMD;
            parsed_valid_o <= 1'b0;
        end else begin
            parsed_valid_o <= rd_pend;
            if (rd_pend) begin
                parsed_o.data <= in_data_i;
                if (phase == fifo_ctrl_pkg::PH_CMD) begin
                    parsed_o.is_header <= 1'b1;
                    parsed_o.cmd       <= hdr.cmd;
                    parsed_o.last      <= 1'b0;
                    cur_cmd            <= hdr.cmd;
                    remaining          <= hdr.len;
                    // Empty packets never leave the command phase
                    if (hdr.len != 6'd0) begin
                        phase <= fifo_ctrl_pkg::PH_PAYLOAD;
                    end
                end else begin
                    parsed_o.is_header <= 1'b0;
                    parsed_o.cmd       <= cur_cmd;
                    parsed_o.last      <= (remaining == 6'd1);
                    remaining          <= remaining - 6'd1;
                    if (remaining == 6'd1) begin
                        phase <= fifo_ctrl_pkg::PH_CMD;
                    end
                end
            end
        end
    end

endmodule

//--- logic/test_sequencer.sv
// Test FSM of the FIFO test controller, checks payloads and requests echoes, streams and reports
`timescale 1ns/100ps

module test_sequencer (
    input  logic                        clk,
    input  logic                        reset_i,
    input  fifo_ctrl_pkg::parsed_byte_t parsed_i,
    input  logic                        parsed_valid_i,
    input  logic                        busy_i,
    output logic                        accept_o,
    output fifo_ctrl_pkg::reply_req_t   req_o,
    output logic                        req_valid_o,
    output logic                        test_ok_o,
    output logic                        test_fail_o
);

    fifo_ctrl_pkg::seq_state_e   state;
    fifo_proto_pkg::test_num_e   test_num;
    fifo_proto_pkg::pkt_header_t hdr;
    fifo_ctrl_pkg::reply_req_t   rpt;
    logic [7:0]                  expected;
    logic                        writer_idle;

    assign hdr         = fifo_proto_pkg::pkt_header_t'(parsed_i.data);
    assign accept_o    = (state == fifo_ctrl_pkg::READ);
    // Busy rises one cycle after the strobe, so the strobe itself counts as busy
    assign writer_idle = ~busy_i & ~req_valid_o;

    // Header plus up to three bytes, header length is the count that follows
    function automatic fifo_ctrl_pkg::reply_req_t make_reply(
        input fifo_proto_pkg::cmd_e cmd,
        input logic [2:0]           n,
        input logic [7:0]           b1,
        input logic [7:0]           b2,
        input logic [7:0]           b3
    );
        fifo_ctrl_pkg::reply_req_t   r;
        fifo_proto_pkg::pkt_header_t h;
        h.cmd      = cmd;
        h.len      = {3'd0, n - 3'd1};
        r.stream   = 1'b0;
        r.count    = n;
        r.bytes[0] = h;
        r.bytes[1] = b1;
        r.bytes[2] = b2;
        r.bytes[3] = b3;
        return r;
    endfunction

    function automatic fifo_ctrl_pkg::reply_req_t make_report(
        input fifo_proto_pkg::err_code_e code,
        input logic [2:0]                n,
        input logic [7:0]                b2,
        input logic [7:0]                b3
    );
        return make_reply(fifo_proto_pkg::TEST_STOPPED, n, code, b2, b3);
    endfunction

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state       <= fifo_ctrl_pkg::READ;
            test_num    <= fifo_proto_pkg::RECEIVE;
            expected    <= 8'd0;
            req_valid_o <= 1'b0;
            test_ok_o   <= 1'b0;
            test_fail_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            case (state)
                fifo_ctrl_pkg::READ: begin
                    if (parsed_valid_i && parsed_i.is_header) begin
                        // ====================
                        // Header bytes
                        // ====================
                        case (parsed_i.cmd)
                            fifo_proto_pkg::TEST_START: begin
                                expected    <= 8'd0;
                                test_ok_o   <= 1'b0;
                                test_fail_o <= 1'b0;
                                if (hdr.len != 6'd1) begin
                                    rpt   <= make_report(fifo_proto_pkg::BAD_START_LENGTH,
                                                         3'd2, 8'd0, 8'd0);
                                    state <= fifo_ctrl_pkg::REPORT;
                                end
                            end
                            fifo_proto_pkg::TEST_DATA: begin
                            end
                            fifo_proto_pkg::TEST_STOP: begin
                                if (hdr.len == 6'd0) begin
                                    rpt <= make_report(fifo_proto_pkg::NONE, 3'd2, 8'd0, 8'd0);
                                end else begin
                                    rpt <= make_report(fifo_proto_pkg::BAD_STOP_LENGTH,
                                                       3'd2, 8'd0, 8'd0);
                                end
                                state <= fifo_ctrl_pkg::REPORT;
                            end
                            default: begin
                                rpt   <= make_report(fifo_proto_pkg::BAD_CMD, 3'd2, 8'd0, 8'd0);
                                state <= fifo_ctrl_pkg::REPORT;
                            end
                        endcase
                    end else if (parsed_valid_i) begin
                        // ====================
                        // Payload bytes
                        // ====================
                        if (parsed_i.cmd == fifo_proto_pkg::TEST_START && parsed_i.last) begin
                            test_num <= fifo_proto_pkg::test_num_e'(parsed_i.data);
                            case (parsed_i.data)
                                fifo_proto_pkg::RECEIVE, fifo_proto_pkg::RECEIVE_SEND: begin
                                end
                                fifo_proto_pkg::SEND: begin
                                    req_o       <= '{stream: 1'b1, default: '0};
                                    req_valid_o <= 1'b1;
                                    state       <= fifo_ctrl_pkg::STREAM;
                                end
                                default: begin
                                    rpt   <= make_report(fifo_proto_pkg::BAD_TEST_NUM, 3'd3,
                                                         parsed_i.data, 8'd0);
                                    state <= fifo_ctrl_pkg::REPORT;
                                end
                            endcase
                        end else if (parsed_i.cmd == fifo_proto_pkg::TEST_DATA) begin
                            if (parsed_i.data == expected) begin
                                expected <= expected + 8'd1;
                                // Loopback echoes each good byte as its own packet
                                if (test_num == fifo_proto_pkg::RECEIVE_SEND) begin
                                    req_o       <= make_reply(fifo_proto_pkg::TEST_DATA, 3'd2,
                                                              parsed_i.data, 8'd0, 8'd0);
                                    req_valid_o <= 1'b1;
                                    state       <= fifo_ctrl_pkg::REPLY;
                                end
                            end else begin
                                rpt   <= make_report(fifo_proto_pkg::BAD_TEST_DATA, 3'd4,
                                                     parsed_i.data, expected);
                                state <= fifo_ctrl_pkg::REPORT;
                            end
                        end
                    end
                end
                fifo_ctrl_pkg::REPLY: begin
                    if (writer_idle) begin
                        state <= fifo_ctrl_pkg::READ;
                    end
                end
                fifo_ctrl_pkg::STREAM: begin
                    if (writer_idle) begin
                        rpt   <= make_report(fifo_proto_pkg::NONE, 3'd2, 8'd0, 8'd0);
                        state <= fifo_ctrl_pkg::REPORT;
                    end
                end
                fifo_ctrl_pkg::REPORT: begin
                    if (writer_idle) begin
                        req_o       <= rpt;
                        req_valid_o <= 1'b1;
                        test_ok_o   <= (rpt.bytes[1] == fifo_proto_pkg::NONE);
                        test_fail_o <= (rpt.bytes[1] != fifo_proto_pkg::NONE);
                        state       <= fifo_ctrl_pkg::DONE;
                    end
                end
                default: begin
                    // Idle until reset
                end
            endcase
        end
    end

endmodule

//--- logic/response_writer.sv
// Output FIFO writer of the FIFO test controller, sends replies or the send-test stream
`timescale 1ns/100ps

`include "fifo_test_config.svh"

module response_writer (
    input  logic                      clk,
    input  logic                      reset_i,
    input  fifo_ctrl_pkg::reply_req_t req_i,
    input  logic                      req_valid_i,
    input  logic                      out_afull_i,
    output logic                      busy_o,
    output logic                      out_wr_o,
    output logic [7:0]                out_data_o
);

    localparam fifo_proto_pkg::pkt_header_t STREAM_HDR = '{
        cmd: fifo_proto_pkg::TEST_DATA,
        len: `FTC_SEND_PAYLOAD
    };

    fifo_ctrl_pkg::wr_state_e         state;
    logic [`FTC_REPLY_BYTES-1:0][7:0] rbuf;
    logic [2:0]                       rcount;
    logic [2:0]                       idx;
    logic [7:0]                       pkts_left;
    logic [5:0]                       pay_left;
    logic [7:0]                       gen_data;

    assign busy_o = (state != fifo_ctrl_pkg::WR_IDLE);

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state    <= fifo_ctrl_pkg::WR_IDLE;
            out_wr_o <= 1'b0;
        end else begin
            out_wr_o <= 1'b0;
            case (state)
                fifo_ctrl_pkg::WR_IDLE: begin
                    if (req_valid_i) begin
                        rbuf      <= req_i.bytes;
                        rcount    <= req_i.count;
                        idx       <= 3'd0;
                        pkts_left <= `FTC_SEND_PACKETS;
                        gen_data  <= 8'd0;
                        state     <= req_i.stream ? fifo_ctrl_pkg::WR_HDR
                                                  : fifo_ctrl_pkg::WR_REPLY;
                    end
                end
                // ====================
                // Buffered reply
                // ====================
                fifo_ctrl_pkg::WR_REPLY: begin
                    if (!out_afull_i) begin
                        out_wr_o   <= 1'b1;
                        out_data_o <= rbuf[idx];
                        idx        <= idx + 3'd1;
                        if (idx == rcount - 3'd1) begin
                            state <= fifo_ctrl_pkg::WR_IDLE;
                        end
                    end
                end
                // ====================
                // Send-test stream
                // ====================
                fifo_ctrl_pkg::WR_HDR: begin
                    if (!out_afull_i) begin
                        out_wr_o   <= 1'b1;
                        out_data_o <= STREAM_HDR;
                        pay_left   <= `FTC_SEND_PAYLOAD;
                        state      <= fifo_ctrl_pkg::WR_PAYLOAD;
                    end
                end
                default: begin
                    if (!out_afull_i) begin
                        out_wr_o   <= 1'b1;
                        out_data_o <= gen_data;
                        // Counter keeps running across packets
                        gen_data   <= gen_data + 8'd1;
                        pay_left   <= pay_left - 6'd1;
                        if (pay_left == 6'd1) begin
                            pkts_left <= pkts_left - 8'd1;
                            state     <= (pkts_left == 8'd1) ? fifo_ctrl_pkg::WR_IDLE
                                                             : fifo_ctrl_pkg::WR_HDR;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- logic/fifo_test_ctrl.sv
// Top level of the FIFO test controller, chains parser, sequencer and writer between two FIFOs
`timescale 1ns/100ps

module fifo_test_ctrl (
    input  logic       clk,
    input  logic       reset_i,
    // Input FIFO
    output logic       in_rd_o,
    input  logic       in_empty_i,
    input  logic [7:0] in_data_i,
    // Output FIFO
    output logic       out_wr_o,
    output logic [7:0] out_data_o,
    input  logic       out_afull_i,
    // Status
    output logic       test_ok_o,
    output logic       test_fail_o
);

    fifo_ctrl_pkg::parsed_byte_t parsed;
    fifo_ctrl_pkg::reply_req_t   req;
    logic                        parsed_valid;
    logic                        accept;
    logic                        req_valid;
    logic                        busy;

    packet_parser i_parser (
        .clk            (clk),
        .reset_i        (reset_i),
        .in_empty_i     (in_empty_i),
        .in_data_i      (in_data_i),
        .accept_i       (accept),
        .in_rd_o        (in_rd_o),
        .parsed_o       (parsed),
        .parsed_valid_o (parsed_valid)
    );

    test_sequencer i_sequencer (
        .clk            (clk),
        .reset_i        (reset_i),
        .parsed_i       (parsed),
        .parsed_valid_i (parsed_valid),
        .busy_i         (busy),
        .accept_o       (accept),
        .req_o          (req),
        .req_valid_o    (req_valid),
        .test_ok_o      (test_ok_o),
        .test_fail_o    (test_fail_o)
    );

    response_writer i_writer (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req),
        .req_valid_i (req_valid),
        .out_afull_i (out_afull_i),
        .busy_o      (busy),
        .out_wr_o    (out_wr_o),
        .out_data_o  (out_data_o)
    );

endmodule

//--- dv/tb_clock_gen.sv
// Free-running testbench clock, instantiated once by the testbench top
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- dv/fifo_test_ctrl_assert.sv
// Concurrent checks on the FIFO test controller ports, attached to its top level by bind
`timescale 1ns/100ps

module fifo_test_ctrl_assert (
    input logic clk,
    input logic reset_i,
    input logic in_rd_o,
    input logic in_empty_i,
    input logic out_wr_o,
    input logic out_afull_i,
    input logic test_ok_o,
    input logic test_fail_o
);

    // Writes only follow a cycle with room in the output FIFO
    wr_after_room: assert property (@(posedge clk) disable iff (reset_i)
        out_wr_o |-> !$past(out_afull_i))
        else $error("Output FIFO written after almost-full was high");

    rd_after_data: assert property (@(posedge clk) disable iff (reset_i)
        in_rd_o |-> !$past(in_empty_i))
        else $error("Input FIFO read while it reported empty");

    // One read in flight at a time
    rd_single_pulse: assert property (@(posedge clk) disable iff (reset_i)
        in_rd_o |=> !in_rd_o)
        else $error("Input FIFO read enable high for two cycles");

    status_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(test_ok_o && test_fail_o))
        else $error("Pass and fail status high together");

endmodule

bind fifo_test_ctrl fifo_test_ctrl_assert i_assert (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_rd_o     (in_rd_o),
    .in_empty_i  (in_empty_i),
    .out_wr_o    (out_wr_o),
    .out_afull_i (out_afull_i),
    .test_ok_o   (test_ok_o),
    .test_fail_o (test_fail_o)
);

//--- dv/fifo_test_ctrl_tb.sv
// Testbench top that runs randomized link tests on the FIFO test controller against a reference model
`timescale 1ns/100ps

`include "fifo_test_config.svh"

module fifo_test_ctrl_tb;

    localparam int NUM_TESTS     = 5;
    localparam int TEST_LIMIT    = 2000;
    localparam int SETTLE_CYCLES = 40;
    localparam int PERIOD_NS     = 40;

    logic       clk;
    logic       reset = 1'b1;
    logic       in_rd;
    logic       in_empty = 1'b1;
    logic [7:0] in_data = 8'd0;
    logic       out_wr;
    logic [7:0] out_data;
    logic       out_afull = 1'b0;
    logic       test_ok;
    logic       test_fail;

    logic [31:0] lfsr = 32'he31d_8044;
    logic [7:0]  stim_q[$];
    logic [7:0]  in_q[$];
    logic [7:0]  out_q[$];
    logic [7:0]  exp_q[$];
    logic        exp_ok;
    logic        afull_seen = 1'b0;
    int          throttle_errs = 0;
    int          total_errs = 0;
    int          failed_tests = 0;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) i_clock (.clk_o(clk));

    fifo_test_ctrl i_dut (
        .clk         (clk),
        .reset_i     (reset),
        .in_rd_o     (in_rd),
        .in_empty_i  (in_empty),
        .in_data_i   (in_data),
        .out_wr_o    (out_wr),
        .out_data_o  (out_data),
        .out_afull_i (out_afull),
        .test_ok_o   (test_ok),
        .test_fail_o (test_fail)
    );

    // ====================
    // Random source
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per returned bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = 8'd0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[6:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] hdr_byte(input fifo_proto_pkg::cmd_e cmd,
                                            input logic [5:0]           len);
        return {cmd, len};
    endfunction

    // ====================
    // FIFO models
    // ====================
    always @(posedge clk) begin
        // Read data shows up one cycle after the read enable
        if (in_rd && in_q.size() > 0) begin
            in_data <= in_q.pop_front();
        end
        in_empty  <= (in_q.size() == 0) || (rand_bits(2) == 8'd0);
        out_afull <= (rand_bits(2) == 8'd0);
        if (out_wr) begin
            out_q.push_back(out_data);
            if (afull_seen) begin
                throttle_errs++;
            end
        end
        afull_seen = out_afull;
    end

    // ====================
    // Stream builders
    // ====================
    task automatic add_start(input logic [7:0] num);
        stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_START, 6'd1));
        stim_q.push_back(num);
    endtask

    // Data packets of 1 to 8 bytes counting up from 0 with one byte optionally corrupted
    task automatic add_data(input int total, input int corrupt_at);
        int         left;
        int         len;
        logic [7:0] val;
        left = total;
        val = 8'd0;
        while (left > 0) begin
            len = 1 + int'(rand_bits(3));
            if (len > left) begin
                len = left;
            end
            stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_DATA, 6'(len)));
            repeat (len) begin
                if (int'(val) == corrupt_at) begin
                    stim_q.push_back(val ^ (8'h01 << rand_bits(3)));
                end else begin
                    stim_q.push_back(val);
                end
                val++;
            end
            left -= len;
        end
    endtask

    // ====================
    // Reference model
    // ====================
    task automatic expect_report(input logic [7:0] code, input int n_extra,
                                 input logic [7:0] b2, input logic [7:0] b3);
        exp_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOPPED, 6'(1 + n_extra)));
        exp_q.push_back(code);
        if (n_extra > 0) begin
            exp_q.push_back(b2);
        end
        if (n_extra > 1) begin
            exp_q.push_back(b3);
        end
        exp_ok = (code == fifo_proto_pkg::NONE);
    endtask

    task automatic predict();
        int         i;
        int         len;
        logic [1:0] cmd;
        logic [7:0] expected;
        logic [7:0] test_num;
        logic [7:0] b;
        bit         done;
        i = 0;
        done = 1'b0;
        expected = 8'd0;
        test_num = fifo_proto_pkg::RECEIVE;
        exp_ok = 1'b0;
        exp_q.delete();
        while (!done && i < stim_q.size()) begin
            cmd = stim_q[i][7:6];
            len = int'(stim_q[i][5:0]);
            i++;
            if (cmd == fifo_proto_pkg::TEST_START && len != 1) begin
                expect_report(fifo_proto_pkg::BAD_START_LENGTH, 0, 8'd0, 8'd0);
                done = 1'b1;
            end else if (cmd == fifo_proto_pkg::TEST_START) begin
                expected = 8'd0;
                test_num = stim_q[i];
                i++;
                if (test_num == fifo_proto_pkg::SEND) begin
                    for (int p = 0; p < `FTC_SEND_PACKETS; p++) begin
                        exp_q.push_back(hdr_byte(fifo_proto_pkg::TEST_DATA, `FTC_SEND_PAYLOAD));
                        for (int k = 0; k < `FTC_SEND_PAYLOAD; k++) begin
                            exp_q.push_back(8'(p * `FTC_SEND_PAYLOAD + k));
                        end
                    end
                    expect_report(fifo_proto_pkg::NONE, 0, 8'd0, 8'd0);
                    done = 1'b1;
                end else if (test_num != fifo_proto_pkg::RECEIVE &&
                             test_num != fifo_proto_pkg::RECEIVE_SEND) begin
                    expect_report(fifo_proto_pkg::BAD_TEST_NUM, 1, test_num, 8'd0);
                    done = 1'b1;
                end
            end else if (cmd == fifo_proto_pkg::TEST_DATA) begin
                for (int k = 0; k < len && !done; k++) begin
                    b = stim_q[i];
                    i++;
                    if (b != expected) begin
                        expect_report(fifo_proto_pkg::BAD_TEST_DATA, 2, b, expected);
                        done = 1'b1;
                    end else begin
                        if (test_num == fifo_proto_pkg::RECEIVE_SEND) begin
                            exp_q.push_back(hdr_byte(fifo_proto_pkg::TEST_DATA, 6'd1));
                            exp_q.push_back(b);
                        end
                        expected++;
                    end
                end
            end else if (cmd == fifo_proto_pkg::TEST_STOP) begin
                expect_report((len == 0) ? fifo_proto_pkg::NONE
                                         : fifo_proto_pkg::BAD_STOP_LENGTH,
                              0, 8'd0, 8'd0);
                done = 1'b1;
            end else begin
                expect_report(fifo_proto_pkg::BAD_CMD, 0, 8'd0, 8'd0);
                done = 1'b1;
            end
        end
    endtask

    // ====================
    // Test runner
    // ====================
    task automatic run_test(input string name);
        int cycles;
        int errs;
        bit done;
        in_q = stim_q;
        out_q.delete();
        throttle_errs = 0;
        predict();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // Report issued and the writer drained
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TEST_LIMIT) begin
            @(negedge clk);
            cycles++;
            done = (test_ok || test_fail) && !i_dut.busy && !i_dut.req_valid;
        end
        // Idle window where later input must not produce output
        repeat (SETTLE_CYCLES) @(negedge clk);
        errs = 0;
        assert (done) else begin
            $display("Test %s timed out waiting for the stop report", name);
            errs++;
        end
        if (done) begin
            assert (out_q.size() == exp_q.size()) else begin
                $display("FAIL %s: output length expected %0d, actual %0d",
                         name, exp_q.size(), out_q.size());
                errs++;
            end
            for (int k = 0; k < exp_q.size() && k < out_q.size(); k++) begin
                assert (out_q[k] == exp_q[k]) else begin
                    $display("FAIL %s: byte %0d expected %02h, actual %02h",
                             name, k, exp_q[k], out_q[k]);
                    errs++;
                end
            end
            assert (test_ok == exp_ok && test_fail == !exp_ok) else begin
                $display("FAIL %s: status ok,fail expected %0b,%0b, actual %0b,%0b",
                         name, exp_ok, !exp_ok, test_ok, test_fail);
                errs++;
            end
            assert (throttle_errs == 0) else begin
                $display("Test %s wrote %0d bytes right after almost-full was high",
                         name, throttle_errs);
                errs++;
            end
        end
        $display("Test %-14s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
        total_errs += errs;
        if (errs != 0) begin
            failed_tests++;
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int    total;
        string name;
        stim_q.delete();
        add_start(fifo_proto_pkg::RECEIVE);
        add_data(8 + int'(rand_bits(4)), -1);
        stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOP, 6'd0));
        run_test("receive");

        stim_q.delete();
        add_start(fifo_proto_pkg::RECEIVE_SEND);
        add_data(8 + int'(rand_bits(4)), -1);
        stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOP, 6'd0));
        run_test("loopback");

        // Trailing STOP is never read
        stim_q.delete();
        add_start(fifo_proto_pkg::SEND);
        stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOP, 6'd0));
        run_test("send");

        stim_q.delete();
        total = 12 + int'(rand_bits(3));
        add_start(fifo_proto_pkg::RECEIVE_SEND);
        add_data(total, int'(rand_bits(3)));
        stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOP, 6'd0));
        run_test("mismatch");

        stim_q.delete();
        case (rand_bits(2))
            8'd0: begin
                name = "bad_start_len";
                stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_START, 6'd2));
                stim_q.push_back(fifo_proto_pkg::RECEIVE);
                stim_q.push_back(8'd0);
            end
            8'd1: begin
                name = "bad_test_num";
                add_start(8'd7);
            end
            8'd2: begin
                name = "bad_stop_len";
                add_start(fifo_proto_pkg::RECEIVE);
                add_data(4, -1);
                stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOP, 6'd3));
                repeat (3) stim_q.push_back(8'd0);
            end
            default: begin
                name = "bad_cmd";
                add_start(fifo_proto_pkg::RECEIVE);
                add_data(4, -1);
                stim_q.push_back(hdr_byte(fifo_proto_pkg::TEST_STOPPED, 6'd0));
            end
        endcase
        run_test(name);

        $display("Tests run: %0d, failed: %0d, errors: %0d", NUM_TESTS, failed_tests, total_errs);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog sized from the per-test cycle budget
    initial begin
        #(NUM_TESTS * TEST_LIMIT * PERIOD_NS);
        $display("Watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
logic/fifo_proto_pkg.sv
logic/fifo_ctrl_pkg.sv
logic/packet_parser.sv
logic/test_sequencer.sv
logic/response_writer.sv
logic/fifo_test_ctrl.sv
dv/tb_clock_gen.sv
dv/fifo_test_ctrl_assert.sv
dv/fifo_test_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIFO test controller simulation with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module fifo_test_ctrl_tb \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
